// File: verilog.f
hdl/alu_pkg.sv
hdl/alu_logic.sv
hdl/alu_arith.sv
hdl/alu_shifter.sv
hdl/alu_simd.sv
hdl/alu_bit_scan.sv
hdl/alu_result_select.sv
hdl/alu_top.sv
test/tb_clock.sv
test/alu_tb.sv

// File: Makefile
TOOL       = verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP        = alu_tb
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then exit 1; fi
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/alu_tb.sv
module alu_tb;

    localparam int PERIOD       = 20;
    localparam int RESET_CYCLES = 4;
    localparam int N_RAND       = 16;

    // vectors per test group, in run order
    localparam int TOTAL_VECS = (6 * N_RAND + 1) + (N_RAND + 3) + (N_RAND + 2) +
                                2 * (N_RAND + 3) + (4 + 3 * N_RAND + 33);
    localparam int WATCHDOG_CYCLES = TOTAL_VECS + RESET_CYCLES + 100;

    typedef struct packed {
        alu_pkg::data_t      result;
        alu_pkg::alu_flags_t flags;
        logic                swap;
        logic                cc_inval;
    } expect_t;

    logic                   clk;
    logic                   rst_n;
    alu_pkg::alu_operands_t ops;
    alu_pkg::alu_ctrl_t     ctrl;
    logic                   of_in;
    alu_pkg::data_t         result;
    alu_pkg::alu_flags_t    flags;
    logic                   swap;
    logic                   cc_inval;

    expect_t expected;
    logic    check_en;
    integer  seed = 76116;
    int      vec_count = 0;
    int      checks = 0;
    int      errors = 0;

    tb_clock #(.PERIOD(PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    alu_top dut0 (
        .ops      (ops),
        .ctrl     (ctrl),
        .of_in    (of_in),
        .result   (result),
        .flags    (flags),
        .swap     (swap),
        .cc_inval (cc_inval)
    );

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic expect_t expected_outputs(input alu_pkg::alu_operands_t o,
                                                 input alu_pkg::alu_ctrl_t c,
                                                 input logic ofi);
        expect_t            e;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        tmp;
        logic signed [31:0] sa;
        logic [32:0]        wide;
        logic [7:0]         low_byte;
        logic               equal;
        logic               found;
        int                 cnt;
        int                 ones;
        e     = '0;
        a     = o.op1[31:0];
        b     = o.op2[31:0];
        sa    = a;
        equal = (a == o.op3[31:0]);
        cnt   = c.shift_by_two ? 2 : int'(o.op2[4:0]);
        found = 1'b0;
        case (c.op)
            alu_pkg::op_and:    e.result = o.op1 & (c.mask_low16 ? 64'hFFFF : o.op2);
            alu_pkg::op_or:     e.result = o.op1 | o.op2;
            alu_pkg::op_not:    e.result = ~o.op1;
            alu_pkg::op_pass_a: e.result = o.op1;
            alu_pkg::op_pass_b: e.result = o.op2;
            alu_pkg::op_add: begin
                wide       = {1'b0, a} + {1'b0, b};
                e.result   = {32'b0, wide[31:0]};
                e.flags.cf = wide[32];
                e.flags.af = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'd15;
                e.flags.of = (a[31] == b[31]) && (wide[31] != a[31]);
            end
            alu_pkg::op_cmpxchg: begin
                // compare is op1 minus op2, borrow style flags
                wide       = {1'b0, a} - {1'b0, b};
                e.result   = equal ? o.op2 : o.op1;
                e.flags.cf = wide[32];
                e.flags.af = (a[3:0] < b[3:0]);
                e.flags.of = (a[31] != b[31]) && (wide[31] != a[31]);
                e.swap     = equal;
            end
            alu_pkg::op_sal: begin
                e.result   = {32'b0, a << cnt};
                tmp        = a << (cnt - 1);
                e.flags.cf = (cnt == 0) ? 1'b0 : tmp[31];
                e.flags.of = (cnt == 1) ? (e.result[31] ^ e.flags.cf) : ofi;
                e.cc_inval = (cnt == 0);
            end
            alu_pkg::op_sar: begin
                e.result   = {32'b0, sa >>> cnt};
                tmp        = a >> (cnt - 1);
                e.flags.cf = (cnt == 0) ? 1'b0 : tmp[0];
                e.flags.of = (cnt == 1) ? 1'b0 : ofi;
                e.cc_inval = (cnt == 0);
            end
            alu_pkg::op_paddw: begin
                e.result[15:0]  = o.op1[15:0] + o.op2[15:0];
                e.result[31:16] = o.op1[31:16] + o.op2[31:16];
                e.result[47:32] = o.op1[47:32] + o.op2[47:32];
                e.result[63:48] = o.op1[63:48] + o.op2[63:48];
            end
            alu_pkg::op_paddd: begin
                e.result[31:0]  = o.op1[31:0] + o.op2[31:0];
                e.result[63:32] = o.op1[63:32] + o.op2[63:32];
            end
            alu_pkg::op_bsf: begin
                for (int i = 0; i < 32; i++) begin
                    tmp = a >> i;
                    if (!found && tmp[0]) begin
                        e.result = 64'(i);
                        found    = 1'b1;
                    end
                end
            end
            default: e.result = '0;
        endcase
        // parity counted bit by bit over the low byte
        ones     = 0;
        low_byte = e.result[7:0];
        for (int i = 0; i < 8; i++) begin
            if (low_byte[0]) begin
                ones++;
            end
            low_byte = low_byte >> 1;
        end
        e.flags.pf = (ones % 2 == 0);
        case (c.size)
            alu_pkg::size_byte:  e.flags.sf = e.result[7];
            alu_pkg::size_word:  e.flags.sf = e.result[15];
            alu_pkg::size_dword: e.flags.sf = e.result[31];
            default:             e.flags.sf = e.result[63];
        endcase
        if (c.op == alu_pkg::op_bsf) begin
            e.flags.zf = (a == 32'd0);
        end else if (c.op == alu_pkg::op_cmpxchg) begin
            e.flags.zf = equal;
        end else begin
            e.flags.zf = (e.result == 64'd0);
        end
        return e;
    endfunction

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic alu_pkg::data_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s = 0x%0h, expected 0x%0h (op %s)", name, got, exp,
                     ctrl.op.name());
        end
    endtask

    task automatic drive_vector(input alu_pkg::alu_op_e op, input alu_pkg::size_e size,
                                input logic mask, input logic by_two,
                                input alu_pkg::data_t a, input alu_pkg::data_t b,
                                input alu_pkg::data_t c, input logic ofi);
        alu_pkg::alu_operands_t o;
        alu_pkg::alu_ctrl_t     k;
        o.op1          = a;
        o.op2          = b;
        o.op3          = c;
        k.op           = op;
        k.size         = size;
        k.mask_low16   = mask;
        k.shift_by_two = by_two;
        @(posedge clk);
        ops      <= o;
        ctrl     <= k;
        of_in    <= ofi;
        expected <= expected_outputs(o, k, ofi);
        check_en <= 1'b1;
        vec_count++;
    endtask

    // last compare of the group has run on the falling edge before this
    task automatic finish_test(input string name, input int first_vec, input int first_err);
        @(posedge clk);
        check_en <= 1'b0;
        $display("%s: %0d vectors, %0d errors", name, vec_count - first_vec,
                 errors - first_err);
    endtask

    always @(negedge clk) begin
        if (check_en) begin
            compare_value("result", result, expected.result);
            compare_value("flags.cf", 64'(flags.cf), 64'(expected.flags.cf));
            compare_value("flags.pf", 64'(flags.pf), 64'(expected.flags.pf));
            compare_value("flags.af", 64'(flags.af), 64'(expected.flags.af));
            compare_value("flags.zf", 64'(flags.zf), 64'(expected.flags.zf));
            compare_value("flags.sf", 64'(flags.sf), 64'(expected.flags.sf));
            compare_value("flags.of", 64'(flags.of), 64'(expected.flags.of));
            compare_value("swap", 64'(swap), 64'(expected.swap));
            compare_value("cc_inval", 64'(cc_inval), 64'(expected.cc_inval));
        end
    end

    //////////////////////////////
    // test groups
    //////////////////////////////

    task automatic logic_ops_test();
        int             v0;
        int             e0;
        alu_pkg::data_t a;
        alu_pkg::data_t b;
        alu_pkg::data_t c;
        logic           ofi;
        v0 = vec_count;
        e0 = errors;
        for (int i = 0; i < N_RAND; i++) begin
            a   = rand_word();
            b   = rand_word();
            c   = rand_word();
            ofi = rand_bit();
            drive_vector(alu_pkg::op_and, alu_pkg::size_e'(i % 4), 1'b0, 1'b0, a, b, c, ofi);
            drive_vector(alu_pkg::op_and, alu_pkg::size_e'((i + 1) % 4), 1'b1, 1'b0,
                         a, b, c, ofi);
            drive_vector(alu_pkg::op_or, alu_pkg::size_e'((i + 2) % 4), 1'b0, 1'b0,
                         a, b, c, ofi);
            drive_vector(alu_pkg::op_not, alu_pkg::size_e'((i + 3) % 4), 1'b0, 1'b0,
                         a, b, c, ofi);
            drive_vector(alu_pkg::op_pass_a, alu_pkg::size_e'(i % 4), 1'b0, 1'b0,
                         a, b, c, ofi);
            drive_vector(alu_pkg::op_pass_b, alu_pkg::size_e'((i + 1) % 4), 1'b0, 1'b0,
                         a, b, c, ofi);
        end
        // disjoint operands, zero result
        drive_vector(alu_pkg::op_and, alu_pkg::size_qword, 1'b0, 1'b0,
                     64'hFFFF0000_FFFF0000, 64'h0000FFFF_0000FFFF, 64'd0, 1'b1);
        finish_test("logic", v0, e0);
    endtask

    task automatic arith_test();
        int v0;
        int e0;
        v0 = vec_count;
        e0 = errors;
        for (int i = 0; i < N_RAND; i++) begin
            drive_vector(alu_pkg::op_add, alu_pkg::size_e'(i % 4), 1'b0, 1'b0,
                         rand_word(), rand_word(), rand_word(), rand_bit());
        end
        drive_vector(alu_pkg::op_add, alu_pkg::size_dword, 1'b0, 1'b0,
                     64'h7FFF_FFFF, 64'h1, 64'd0, 1'b1);
        drive_vector(alu_pkg::op_add, alu_pkg::size_dword, 1'b0, 1'b0,
                     64'hFFFF_FFFF, 64'h1, 64'd0, 1'b1);
        drive_vector(alu_pkg::op_add, alu_pkg::size_byte, 1'b0, 1'b0,
                     64'h0F, 64'h01, 64'd0, 1'b1);
        finish_test("arith", v0, e0);
    endtask

    task automatic cmpxchg_test();
        int             v0;
        int             e0;
        alu_pkg::data_t a;
        alu_pkg::data_t c;
        v0 = vec_count;
        e0 = errors;
        a  = rand_word();
        c  = rand_word();
        // upper half of op3 differs, only the low dword counts
        drive_vector(alu_pkg::op_cmpxchg, alu_pkg::size_dword, 1'b0, 1'b0,
                     a, rand_word(), {c[63:32], a[31:0]}, rand_bit());
        drive_vector(alu_pkg::op_cmpxchg, alu_pkg::size_dword, 1'b0, 1'b0,
                     a, rand_word(), a ^ 64'h1, rand_bit());
        for (int i = 0; i < N_RAND; i++) begin
            a = rand_word();
            c = rand_word();
            if (i % 2 == 0) begin
                c[31:0] = a[31:0];
            end
            drive_vector(alu_pkg::op_cmpxchg, alu_pkg::size_e'(i % 4), 1'b0, 1'b0,
                         a, rand_word(), c, rand_bit());
        end
        finish_test("cmpxchg", v0, e0);
    endtask

    task automatic shift_test();
        int               v0;
        int               e0;
        alu_pkg::alu_op_e op;
        alu_pkg::data_t   a;
        v0 = vec_count;
        e0 = errors;
        for (int k = 0; k < 2; k++) begin
            op = (k == 0) ? alu_pkg::op_sal : alu_pkg::op_sar;
            // count 0, then count 1, with junk above the 5-bit count
            drive_vector(op, alu_pkg::size_dword, 1'b0, 1'b0, rand_word() | 64'h8000_0000,
                         rand_word() & ~64'h1F, 64'd0, rand_bit());
            drive_vector(op, alu_pkg::size_dword, 1'b0, 1'b0, rand_word() | 64'h8000_0000,
                         (rand_word() & ~64'h1F) | 64'h1, 64'd0, rand_bit());
            for (int i = 0; i < N_RAND; i++) begin
                a = rand_word();
                if (i % 2 == 0) begin
                    a[31] = 1'b1;
                end
                drive_vector(op, alu_pkg::size_e'(i % 4), 1'b0, 1'b0, a, rand_word(),
                             64'd0, rand_bit());
            end
            drive_vector(op, alu_pkg::size_dword, 1'b0, 1'b1, rand_word() | 64'h8000_0000,
                         rand_word(), 64'd0, rand_bit());
        end
        finish_test("shift", v0, e0);
    endtask

    task automatic packed_scan_test();
        int             v0;
        int             e0;
        alu_pkg::data_t a;
        alu_pkg::data_t b;
        v0 = vec_count;
        e0 = errors;
        // every lane overflows
        a = 64'hFFFF_8000_7FFF_FFFF;
        b = 64'h0001_8000_0001_0001;
        drive_vector(alu_pkg::op_paddw, alu_pkg::size_word, 1'b0, 1'b0, a, b, 64'd0, 1'b0);
        drive_vector(alu_pkg::op_paddd, alu_pkg::size_dword, 1'b0, 1'b0, a, b, 64'd0, 1'b0);
        a = 64'hFFFF_FFFF_8000_0000;
        b = 64'h0000_0001_8000_0000;
        drive_vector(alu_pkg::op_paddw, alu_pkg::size_word, 1'b0, 1'b0, a, b, 64'd0, 1'b0);
        drive_vector(alu_pkg::op_paddd, alu_pkg::size_qword, 1'b0, 1'b0, a, b, 64'd0, 1'b0);
        for (int i = 0; i < N_RAND; i++) begin
            a = rand_word();
            b = rand_word();
            drive_vector(alu_pkg::op_paddw, alu_pkg::size_e'(i % 4), 1'b0, 1'b0,
                         a, b, 64'd0, rand_bit());
            drive_vector(alu_pkg::op_paddd, alu_pkg::size_e'(i % 4), 1'b0, 1'b0,
                         a, b, 64'd0, rand_bit());
            drive_vector(alu_pkg::op_bsf, alu_pkg::size_e'(i % 4), 1'b0, 1'b0,
                         rand_word(), rand_word(), 64'd0, rand_bit());
        end
        // one set bit at a time, upper half is ignored
        for (int i = 0; i < 32; i++) begin
            a = rand_word();
            a[31:0] = 32'h1 << i;
            drive_vector(alu_pkg::op_bsf, alu_pkg::size_dword, 1'b0, 1'b0, a, 64'd0,
                         64'd0, 1'b0);
        end
        a = rand_word();
        a[31:0] = 32'd0;
        drive_vector(alu_pkg::op_bsf, alu_pkg::size_dword, 1'b0, 1'b0, a, 64'd0, 64'd0, 1'b0);
        finish_test("packed_scan", v0, e0);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        ops      = '0;
        ctrl     = '0;
        of_in    = 1'b0;
        expected = '0;
        check_en = 1'b0;
        wait (rst_n === 1'b1);
        logic_ops_test();
        arith_test();
        cmpxchg_test();
        shift_test();
        packed_scan_test();
        $display("total: %0d vectors, %0d checks, %0d errors", vec_count, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("watchdog expired before the tests completed");
        $display("Test failures found");
        $finish;
    end

endmodule

// File: test/tb_clock.sv
module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset held low for a few rising edges
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: hdl/alu_top.sv
module alu_top (
    input  alu_pkg::alu_operands_t ops,
    input  alu_pkg::alu_ctrl_t     ctrl,
    input  logic                   of_in,
    output alu_pkg::data_t         result,
    output alu_pkg::alu_flags_t    flags,
    output logic                   swap,
    output logic                   cc_inval
);

    alu_pkg::data_t       and_res;
    alu_pkg::data_t       or_res;
    alu_pkg::data_t       not_res;
    alu_pkg::data_t       pass_a_res;
    alu_pkg::data_t       pass_b_res;
    alu_pkg::data_t       sum;
    alu_pkg::data_t       shift_res;
    alu_pkg::data_t       paddw_res;
    alu_pkg::data_t       paddd_res;
    alu_pkg::data_t       scan_index;
    alu_pkg::unit_flags_t arith_flags;
    alu_pkg::unit_flags_t shift_flags;
    logic                 equal;
    logic                 count_zero;
    logic                 src_zero;

    //////////////////////////////
    // functional units
    //////////////////////////////

    alu_logic u_logic (
        .ops        (ops),
        .mask_low16 (ctrl.mask_low16),
        .and_res    (and_res),
        .or_res     (or_res),
        .not_res    (not_res),
        .pass_a_res (pass_a_res),
        .pass_b_res (pass_b_res)
    );

    alu_arith u_arith (
        .op1   (ops.op1),
        .op2   (ops.op2),
        .op3   (ops.op3),
        .op    (ctrl.op),
        .sum   (sum),
        .flags (arith_flags),
        .equal (equal)
    );

    alu_shifter u_shifter (
        .op1          (ops.op1),
        .op2          (ops.op2),
        .op           (ctrl.op),
        .shift_by_two (ctrl.shift_by_two),
        .of_in        (of_in),
        .result       (shift_res),
        .flags        (shift_flags),
        .count_zero   (count_zero)
    );

    alu_simd u_simd (
        .op1       (ops.op1),
        .op2       (ops.op2),
        .paddw_res (paddw_res),
        .paddd_res (paddd_res)
    );

    // bsf scans op1
    alu_bit_scan u_bit_scan (
        .src      (ops.op1),
        .index    (scan_index),
        .src_zero (src_zero)
    );

    //////////////////////////////
    // output select
    //////////////////////////////

    alu_result_select u_result_select (
        .ctrl        (ctrl),
        .and_res     (and_res),
        .or_res      (or_res),
        .not_res     (not_res),
        .pass_a_res  (pass_a_res),
        .pass_b_res  (pass_b_res),
        .sum         (sum),
        .shift_res   (shift_res),
        .paddw_res   (paddw_res),
        .paddd_res   (paddd_res),
        .scan_index  (scan_index),
        .arith_flags (arith_flags),
        .shift_flags (shift_flags),
        .equal       (equal),
        .count_zero  (count_zero),
        .src_zero    (src_zero),
        .result      (result),
        .flags       (flags),
        .swap        (swap),
        .cc_inval    (cc_inval)
    );

endmodule

// File: hdl/alu_result_select.sv
module alu_result_select (
    input  alu_pkg::alu_ctrl_t   ctrl,
    input  alu_pkg::data_t       and_res,
    input  alu_pkg::data_t       or_res,
    input  alu_pkg::data_t       not_res,
    input  alu_pkg::data_t       pass_a_res,
    input  alu_pkg::data_t       pass_b_res,
    input  alu_pkg::data_t       sum,
    input  alu_pkg::data_t       shift_res,
    input  alu_pkg::data_t       paddw_res,
    input  alu_pkg::data_t       paddd_res,
    input  alu_pkg::data_t       scan_index,
    input  alu_pkg::unit_flags_t arith_flags,
    input  alu_pkg::unit_flags_t shift_flags,
    input  logic                 equal,
    input  logic                 count_zero,
    input  logic                 src_zero,
    output alu_pkg::data_t       result,
    output alu_pkg::alu_flags_t  flags,
    output logic                 swap,
    output logic                 cc_inval
);

    alu_pkg::unit_flags_t unit_flags;
    logic                 is_shift;

    assign is_shift = (ctrl.op == alu_pkg::op_sar) || (ctrl.op == alu_pkg::op_sal);

    //////////////////////////////
    // result and unit flags
    //////////////////////////////

    always_comb begin
        unit_flags = '0;
        case (ctrl.op)
            alu_pkg::op_and:     result = and_res;
            alu_pkg::op_add: begin
                result     = sum;
                unit_flags = arith_flags;
            end
            alu_pkg::op_bsf:     result = scan_index;
            alu_pkg::op_pass_b:  result = pass_b_res;
            alu_pkg::op_pass_a:  result = pass_a_res;
            alu_pkg::op_cmpxchg: begin
                // match loads the source, otherwise the destination comes back
                result     = equal ? pass_b_res : pass_a_res;
                unit_flags = arith_flags;
            end
            alu_pkg::op_not:     result = not_res;
            alu_pkg::op_or:      result = or_res;
            alu_pkg::op_paddw:   result = paddw_res;
            alu_pkg::op_paddd:   result = paddd_res;
            alu_pkg::op_sar, alu_pkg::op_sal: begin
                result     = shift_res;
                unit_flags = shift_flags;
            end
            default:             result = '0;
        endcase
    end

    //////////////////////////////
    // condition codes
    //////////////////////////////

    always_comb begin
        flags.cf = unit_flags.cf;
        flags.af = unit_flags.af;
        flags.of = unit_flags.of;
        // even parity of the low byte
        flags.pf = ~^result[7:0];
        case (ctrl.size)
            alu_pkg::size_byte:  flags.sf = result[7];
            alu_pkg::size_word:  flags.sf = result[15];
            alu_pkg::size_dword: flags.sf = result[31];
            default:             flags.sf = result[alu_pkg::DATA_W-1];
        endcase
        if (ctrl.op == alu_pkg::op_bsf) begin
            flags.zf = src_zero;
        end else if (ctrl.op == alu_pkg::op_cmpxchg) begin
            flags.zf = equal;
        end else begin
            flags.zf = (result == '0);
        end
    end

    // a zero-count shift leaves the flags as they were
    assign swap     = equal && (ctrl.op == alu_pkg::op_cmpxchg);
    assign cc_inval = count_zero && is_shift;

endmodule

// File: hdl/alu_bit_scan.sv
module alu_bit_scan (
    input  alu_pkg::data_t src,
    output alu_pkg::data_t index,
    output logic           src_zero
);

    logic [alu_pkg::SHIFT_CNT_W-1:0] pos;

    // scan down from the top, the lowest set bit is written last
    always_comb begin
        pos = '0;
        for (int i = alu_pkg::HALF_W - 1; i >= 0; i--) begin
            if (src[i]) begin
                pos = i[alu_pkg::SHIFT_CNT_W-1:0];
            end
        end
    end

    // empty source leaves pos at 0
    assign src_zero = ~|src[alu_pkg::HALF_W-1:0];

    assign index = {{(alu_pkg::DATA_W-alu_pkg::SHIFT_CNT_W){1'b0}}, pos};

endmodule

// File: hdl/alu_simd.sv
module alu_simd (
    input  alu_pkg::data_t op1,
    input  alu_pkg::data_t op2,
    output alu_pkg::data_t paddw_res,
    output alu_pkg::data_t paddd_res
);

    // lanes wrap, carries never leave a lane

    // paddw, four word lanes
    for (genvar w = 0; w < alu_pkg::DATA_W / (alu_pkg::HALF_W / 2); w++) begin : g_word
        assign paddw_res[w*(alu_pkg::HALF_W/2) +: alu_pkg::HALF_W/2] =
            op1[w*(alu_pkg::HALF_W/2) +: alu_pkg::HALF_W/2] +
            op2[w*(alu_pkg::HALF_W/2) +: alu_pkg::HALF_W/2];
    end

    // paddd, two dword lanes
    for (genvar d = 0; d < alu_pkg::DATA_W / alu_pkg::HALF_W; d++) begin : g_dword
        assign paddd_res[d*alu_pkg::HALF_W +: alu_pkg::HALF_W] =
            op1[d*alu_pkg::HALF_W +: alu_pkg::HALF_W] +
            op2[d*alu_pkg::HALF_W +: alu_pkg::HALF_W];
    end

endmodule

// File: hdl/alu_shifter.sv
module alu_shifter (
    input  alu_pkg::data_t       op1,
    input  alu_pkg::data_t       op2,
    input  alu_pkg::alu_op_e     op,
    input  logic                 shift_by_two,
    input  logic                 of_in,
    output alu_pkg::data_t       result,
    output alu_pkg::unit_flags_t flags,
    output logic                 count_zero
);

    logic [alu_pkg::SHIFT_CNT_W-1:0] cnt;
    logic [alu_pkg::HALF_W-1:0]      a;
    logic [alu_pkg::HALF_W:0]        sal_ext;
    logic signed [alu_pkg::HALF_W:0] sar_ext;
    logic [alu_pkg::HALF_W-1:0]      res;
    logic                            cf;
    logic                            is_sar;

    // count is masked to 5 bits, so nothing over-shifts
    assign cnt = shift_by_two ? alu_pkg::SHIFT_CNT_W'(2) : op2[alu_pkg::SHIFT_CNT_W-1:0];
    assign a   = op1[alu_pkg::HALF_W-1:0];

    assign is_sar     = (op == alu_pkg::op_sar);
    assign count_zero = (cnt == '0);

    //////////////////////////////
    // shifts with a carry slot
    //////////////////////////////

    // extra bit above the msb catches the last bit out on the left
    assign sal_ext = {1'b0, a} << cnt;
    // extra bit below the lsb catches it on the right
    assign sar_ext = $signed({a, 1'b0}) >>> cnt;

    always_comb begin
        if (is_sar) begin
            res = sar_ext[alu_pkg::HALF_W:1];
            cf  = sar_ext[0];
        end else begin
            res = sal_ext[alu_pkg::HALF_W-1:0];
            cf  = sal_ext[alu_pkg::HALF_W];
        end
    end

    assign result = {{(alu_pkg::DATA_W-alu_pkg::HALF_W){1'b0}}, res};

    always_comb begin
        flags.cf = cf;
        flags.af = 1'b0;
        // of is only defined for single-bit shifts
        if (cnt == alu_pkg::SHIFT_CNT_W'(1)) begin
            flags.of = is_sar ? 1'b0 : (res[alu_pkg::HALF_W-1] ^ cf);
        end else begin
            flags.of = of_in;
        end
    end

endmodule

// File: hdl/alu_arith.sv
module alu_arith (
    input  alu_pkg::data_t       op1,
    input  alu_pkg::data_t       op2,
    input  alu_pkg::data_t       op3,
    input  alu_pkg::alu_op_e     op,
    output alu_pkg::data_t       sum,
    output alu_pkg::unit_flags_t flags,
    output logic                 equal
);

    logic                       sub;
    logic [alu_pkg::HALF_W-1:0] a;
    logic [alu_pkg::HALF_W-1:0] b_eff;
    logic [alu_pkg::HALF_W-1:0] res;
    logic                       carry;

    // cmpxchg compares by subtracting, everything else adds
    assign sub = (op == alu_pkg::op_cmpxchg);

    assign a     = op1[alu_pkg::HALF_W-1:0];
    assign b_eff = sub ? ~op2[alu_pkg::HALF_W-1:0] : op2[alu_pkg::HALF_W-1:0];

    //////////////////////////////
    // single 32-bit adder
    //////////////////////////////

    // a - b done as a + ~b + 1
    assign {carry, res} = {1'b0, a} + {1'b0, b_eff} + {{alu_pkg::HALF_W{1'b0}}, sub};

    assign sum = {{(alu_pkg::DATA_W-alu_pkg::HALF_W){1'b0}}, res};

    always_comb begin
        // borrow is the inverted carry out of a + ~b + 1
        flags.cf = carry ^ sub;
        // carry or borrow into bit 4, same form for add and sub
        flags.af = a[4] ^ op2[4] ^ res[4];
        // like signs in, other sign out
        flags.of = (a[alu_pkg::HALF_W-1] == b_eff[alu_pkg::HALF_W-1]) &&
                   (res[alu_pkg::HALF_W-1] != a[alu_pkg::HALF_W-1]);
    end

    // accumulator against destination, low dword only
    assign equal = (op1[alu_pkg::HALF_W-1:0] == op3[alu_pkg::HALF_W-1:0]);

endmodule

// File: hdl/alu_logic.sv
module alu_logic (
    input  alu_pkg::alu_operands_t ops,
    input  logic                   mask_low16,
    output alu_pkg::data_t         and_res,
    output alu_pkg::data_t         or_res,
    output alu_pkg::data_t         not_res,
    output alu_pkg::data_t         pass_a_res,
    output alu_pkg::data_t         pass_b_res
);

    alu_pkg::data_t and_src;

    // second and operand, op2 or the low-word mask
    assign and_src = mask_low16 ? alu_pkg::MASK_LOW16 : ops.op2;

    assign and_res = ops.op1 & and_src;
    assign or_res  = ops.op1 | ops.op2;

    // not only looks at op1
    assign not_res = ~ops.op1;

    // moves
    assign pass_a_res = ops.op1;
    assign pass_b_res = ops.op2;

endmodule

// File: hdl/alu_pkg.sv
package alu_pkg;

    //////////////////////////////
    // widths and constants
    //////////////////////////////

    // operand and result width
    localparam int DATA_W = 64;
    // scalar add and shift datapath
    localparam int HALF_W = 32;
    // shift count as on x86, also wide enough for a 32-bit bit index
    localparam int SHIFT_CNT_W = 5;

    typedef logic [DATA_W-1:0] data_t;

    // and mask, keeps the low word of op1
    localparam data_t MASK_LOW16 = {{(DATA_W-16){1'b0}}, 16'hFFFF};

    //////////////////////////////
    // encodings
    //////////////////////////////

    typedef enum logic [4:0] {
        op_and     = 5'd0,
        op_add     = 5'd1,
        op_bsf     = 5'd2,
        op_pass_b  = 5'd3,
        op_pass_a  = 5'd4,
        op_cmpxchg = 5'd7,
        op_not     = 5'd9,
        op_or      = 5'd10,
        op_paddw   = 5'd11,
        op_paddd   = 5'd12,
        op_sar     = 5'd17,
        op_sal     = 5'd18
    } alu_op_e;

    // operand size, picks the sign bit
    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_word  = 2'd1,
        size_dword = 2'd2,
        size_qword = 2'd3
    } size_e;

    //////////////////////////////
    // bundles
    //////////////////////////////

    typedef struct packed {
        data_t op1;
        data_t op2;
        data_t op3;
    } alu_operands_t;

    typedef struct packed {
        alu_op_e op;
        size_e   size;
        logic    mask_low16;
        logic    shift_by_two;
    } alu_ctrl_t;

    // flags a functional unit can produce itself
    typedef struct packed {
        logic cf;
        logic af;
        logic of;
    } unit_flags_t;

    typedef struct packed {
        logic cf;
        logic pf;
        logic af;
        logic zf;
        logic sf;
        logic of;
    } alu_flags_t;

endpackage
